/* rtl/video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal timing in pixels, kept tiny for short simulation frames
`define H_ACTIVE     32
`define H_FP         2
`define H_SYNC       4
`define H_BP         2
`define H_TOTAL      (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// Vertical timing in lines
`define V_ACTIVE     16
`define V_FP         1
`define V_SYNC       2
`define V_BP         1
`define V_TOTAL      (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// Bits per colour channel
`define COLOR_W      8
`define FRAME_CNT_W  32
`define BLINK_SEL_W  3

`endif

/* rtl/video_pkg.sv */
`default_nettype none

`include "video_defines.svh"

package video_pkg;

    // One pixel colour, red in the upper bits
    typedef struct packed {
        logic [`COLOR_W-1:0] r;
        logic [`COLOR_W-1:0] g;
        logic [`COLOR_W-1:0] b;
    } rgb_t;

    // Sync levels as seen at the connector, hs and vs active low
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
    } sync_t;

    // Position inside the active area
    typedef struct packed {
        logic [5:0] x;
        logic [5:0] y;
    } pix_pos_t;

    // Blanked and no sync pulse
    localparam sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, de: 1'b0};

endpackage

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

`include "video_defines.svh"

package core_pkg;
    import video_pkg::*;

    // Register map of the configuration block
    typedef enum logic [2:0] {
        REG_MODE  = 3'd0,
        REG_BG_R  = 3'd1,
        REG_BG_G  = 3'd2,
        REG_BG_B  = 3'd3,
        REG_BLINK = 3'd4
    } reg_addr_e;

    typedef enum logic [1:0] {
        PAT_OFF   = 2'd0,
        PAT_SOLID = 2'd1,
        PAT_BARS  = 2'd2,
        PAT_GRID  = 2'd3
    } pattern_e;

    typedef struct packed {
        pattern_e                mode;
        rgb_t                    bg;
        logic [`BLINK_SEL_W-1:0] blink_sel;
    } core_cfg_t;

    localparam core_cfg_t CFG_RESET = '{mode: PAT_OFF, bg: '0, blink_sel: '0};

endpackage

`default_nettype wire

/* rtl/video_timing.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module video_timing
    import video_pkg::*;
(
    input  wire                     clk50,
    input  wire                     rst_n,
    output logic                    pix_ce,
    output sync_t                   sync,
    output pix_pos_t                pos,
    output logic [`FRAME_CNT_W-1:0] frame_cnt
);

    logic [5:0] h_cnt;
    logic [5:0] v_cnt;
    logic       h_last;
    logic       v_last;
    sync_t      sync_nxt;

    // Pixel enable at half the clk50 rate
    always_ff @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            pix_ce <= 1'b0;
        end else begin
            pix_ce <= ~pix_ce;
        end
    end

    assign h_last = (h_cnt == 6'(`H_TOTAL - 1));
    assign v_last = (v_cnt == 6'(`V_TOTAL - 1));

    // Counters, frame count bumps when the line counter wraps
    always_ff @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            frame_cnt <= '0;
        end else if (pix_ce) begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt     <= '0;
                    frame_cnt <= frame_cnt + `FRAME_CNT_W'(1);
                end else begin
                    v_cnt <= v_cnt + 6'd1;
                end
            end else begin
                h_cnt <= h_cnt + 6'd1;
            end
        end
    end

    // Sync pulses sit after the front porch
    always_comb begin
        sync_nxt.hs = !((h_cnt >= 6'(`H_ACTIVE + `H_FP)) &&
                        (h_cnt <  6'(`H_ACTIVE + `H_FP + `H_SYNC)));
        sync_nxt.vs = !((v_cnt >= 6'(`V_ACTIVE + `V_FP)) &&
                        (v_cnt <  6'(`V_ACTIVE + `V_FP + `V_SYNC)));
        sync_nxt.de = (h_cnt < 6'(`H_ACTIVE)) && (v_cnt < 6'(`V_ACTIVE));
    end

    always_ff @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            sync <= SYNC_IDLE;
        end else if (pix_ce) begin
            sync <= sync_nxt;
        end
    end

    // Position travels with the decoded sync
    always_ff @(posedge clk50) begin
        if (pix_ce) begin
            pos <= '{x: h_cnt, y: v_cnt};
        end
    end

endmodule

`default_nettype wire

/* rtl/core_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module core_regs
    import core_pkg::*;
(
    input  wire                     clk50,
    input  wire                     rst_n,
    input  wire                     cfg_wr,
    input  wire reg_addr_e          cfg_addr,
    input  wire [7:0]               cfg_data,
    input  wire [`FRAME_CNT_W-1:0]  frame_cnt,
    output core_cfg_t               cfg,
    output logic                    led_user
);

    // Write-only registers, one field per address
    always_ff @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= CFG_RESET;
        end else if (cfg_wr) begin
            case (cfg_addr)
                REG_MODE: begin
                    cfg.mode <= pattern_e'(cfg_data[1:0]);
                end
                REG_BG_R: begin
                    cfg.bg.r <= cfg_data[`COLOR_W-1:0];
                end
                REG_BG_G: begin
                    cfg.bg.g <= cfg_data[`COLOR_W-1:0];
                end
                REG_BG_B: begin
                    cfg.bg.b <= cfg_data[`COLOR_W-1:0];
                end
                REG_BLINK: begin
                    cfg.blink_sel <= cfg_data[`BLINK_SEL_W-1:0];
                end
                // Unmapped addresses leave everything as it was
                default: begin
                end
            endcase
        end
    end

    // LED blinks at the rate of the selected frame counter bit
    always_ff @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            led_user <= 1'b0;
        end else begin
            led_user <= frame_cnt[cfg.blink_sel];
        end
    end

endmodule

`default_nettype wire

/* rtl/pattern_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module pattern_gen
    import video_pkg::*;
    import core_pkg::*;
(
    input  wire            clk50,
    input  wire            rst_n,
    input  wire            pix_ce,
    input  wire sync_t     sync_in,
    input  wire pix_pos_t  pos,
    input  wire core_cfg_t cfg,
    output sync_t          sync_out,
    output rgb_t           rgb
);

    localparam logic [`COLOR_W-1:0] FULL = '1;
    localparam logic [`COLOR_W-1:0] NONE = '0;

    logic [2:0] bar_idx;
    logic       on_grid;
    rgb_t       bar_rgb;
    rgb_t       pix_rgb;

    // Bars are four pixels wide
    assign bar_idx = pos.x[4:2];
    assign on_grid = (pos.x[2:0] == 3'd0) || (pos.y[2:0] == 3'd0);

    always_comb begin
        case (bar_idx)
            3'd0:    bar_rgb = '{r: NONE, g: NONE, b: NONE};
            3'd1:    bar_rgb = '{r: NONE, g: NONE, b: FULL};
            3'd2:    bar_rgb = '{r: NONE, g: FULL, b: NONE};
            3'd3:    bar_rgb = '{r: NONE, g: FULL, b: FULL};
            3'd4:    bar_rgb = '{r: FULL, g: NONE, b: NONE};
            3'd5:    bar_rgb = '{r: FULL, g: NONE, b: FULL};
            3'd6:    bar_rgb = '{r: FULL, g: FULL, b: NONE};
            default: bar_rgb = '{r: FULL, g: FULL, b: FULL};
        endcase
    end

    // Blanking forces black whatever the mode
    always_comb begin
        if (!sync_in.de) begin
            pix_rgb = '0;
        end else begin
            case (cfg.mode)
                PAT_SOLID: pix_rgb = cfg.bg;
                PAT_BARS:  pix_rgb = bar_rgb;
                PAT_GRID:  pix_rgb = on_grid ? '{r: FULL, g: FULL, b: FULL} : cfg.bg;
                default:   pix_rgb = '0;
            endcase
        end
    end

    // One pixel of latency, colour and sync stay aligned
    always_ff @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            sync_out <= SYNC_IDLE;
            rgb      <= '0;
        end else if (pix_ce) begin
            sync_out <= sync_in;
            rgb      <= pix_rgb;
        end
    end

endmodule

`default_nettype wire

/* rtl/emu_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module emu_core
    import video_pkg::*;
    import core_pkg::*;
(
    input  wire                     clk50,
    input  wire                     rst_n,
    input  wire                     cfg_wr,
    input  wire reg_addr_e          cfg_addr,
    input  wire [7:0]               cfg_data,
    output logic                    vga_ce,
    output logic [`COLOR_W-1:0]     vga_r,
    output logic [`COLOR_W-1:0]     vga_g,
    output logic [`COLOR_W-1:0]     vga_b,
    output logic                    vga_hs,
    output logic                    vga_vs,
    output logic                    vga_de,
    output logic [`FRAME_CNT_W-1:0] frame_cnt,
    output logic                    led_user
);

    logic      pix_ce;
    sync_t     tim_sync;
    pix_pos_t  tim_pos;
    core_cfg_t cfg;
    sync_t     pix_sync;
    rgb_t      pix_rgb;

    video_timing u_timing (
        .clk50      ( clk50     ),
        .rst_n      ( rst_n     ),
        .pix_ce     ( pix_ce    ),
        .sync       ( tim_sync  ),
        .pos        ( tim_pos   ),
        .frame_cnt  ( frame_cnt )
    );

    core_regs u_regs (
        .clk50      ( clk50     ),
        .rst_n      ( rst_n     ),
        .cfg_wr     ( cfg_wr    ),
        .cfg_addr   ( cfg_addr  ),
        .cfg_data   ( cfg_data  ),
        .frame_cnt  ( frame_cnt ),
        .cfg        ( cfg       ),
        .led_user   ( led_user  )
    );

    pattern_gen u_pattern (
        .clk50      ( clk50     ),
        .rst_n      ( rst_n     ),
        .pix_ce     ( pix_ce    ),
        .sync_in    ( tim_sync  ),
        .pos        ( tim_pos   ),
        .cfg        ( cfg       ),
        .sync_out   ( pix_sync  ),
        .rgb        ( pix_rgb   )
    );

    // Flat VGA outputs
    assign vga_ce = pix_ce;
    assign vga_r  = pix_rgb.r;
    assign vga_g  = pix_rgb.g;
    assign vga_b  = pix_rgb.b;
    assign vga_hs = pix_sync.hs;
    assign vga_vs = pix_sync.vs;
    assign vga_de = pix_sync.de;

endmodule

`default_nettype wire

/* verif/emu_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module emu_asserts
    import video_pkg::*;
(
    input wire        clk50,
    input wire        rst_n,
    input wire        pix_ce,
    input wire sync_t sync
);

    int hs_low_ce;
    int assert_errors = 0;

    // Pixel enables seen while hs is low
    always @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            hs_low_ce <= 0;
        end else if (sync.hs) begin
            hs_low_ce <= 0;
        end else if (pix_ce) begin
            hs_low_ce <= hs_low_ce + 1;
        end
    end

    ce_alternates: assert property (
        @(posedge clk50) disable iff (!rst_n) pix_ce |=> !pix_ce
    ) else begin
        assert_errors = assert_errors + 1;
        $error("pix_ce was high on two consecutive cycles");
    end

    de_blank_in_sync: assert property (
        @(posedge clk50) disable iff (!rst_n) (!sync.hs || !sync.vs) |-> !sync.de
    ) else begin
        assert_errors = assert_errors + 1;
        $error("de was high during a sync pulse");
    end

    hs_pulse_width: assert property (
        @(posedge clk50) disable iff (!rst_n) $rose(sync.hs) |-> (hs_low_ce == `H_SYNC)
    ) else begin
        assert_errors = assert_errors + 1;
        $error("hs pulse did not last the expected number of pixels");
    end

endmodule

bind video_timing emu_asserts u_asserts (
    .clk50  ( clk50  ),
    .rst_n  ( rst_n  ),
    .pix_ce ( pix_ce ),
    .sync   ( sync   )
);

`default_nettype wire

/* verif/emu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module emu_checker
    import video_pkg::*;
    import core_pkg::*;
(
    input wire                    clk50,
    input wire                    rst_n,
    input wire                    vga_ce,
    input wire [`COLOR_W-1:0]     vga_r,
    input wire [`COLOR_W-1:0]     vga_g,
    input wire [`COLOR_W-1:0]     vga_b,
    input wire                    vga_hs,
    input wire                    vga_vs,
    input wire                    vga_de,
    input wire [`FRAME_CNT_W-1:0] frame_cnt,
    input wire                    led_user
);

    // Updated by the testbench after each set of register writes
    core_cfg_t exp_cfg = '{mode: PAT_OFF, bg: '0, blink_sel: '0};
    int        cfg_seq = 0;

    int seen_seq      = 0;
    int frames_since  = 2;
    int pix_errors    = 0;
    int led_errors    = 0;
    int frame_errors  = 0;
    int timing_errors = 0;
    int pix_checked   = 0;

    int                      x;
    int                      y;
    int                      hs_gap;
    int                      vs_gap;
    logic                    prev_de;
    logic                    prev_hs;
    logic                    prev_vs;
    logic                    seen_hs;
    logic                    seen_vs;
    logic [`FRAME_CNT_W-1:0] vs_falls;
    logic [`FRAME_CNT_W-1:0] prev_fc;
    rgb_t                    exp_pix;
    bit                      pix_bad;
    logic                    armed;

    // Skip the frame in which the writes landed
    assign armed = (cfg_seq == seen_seq) && (frames_since >= 1);

    function automatic bit value_differs(input string name, input logic [31:0] exp_val,
                                         input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp_val, act_val, $time);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic rgb_t expected_rgb(input int px, input int py, input core_cfg_t c);
        rgb_t res;
        int   bar;
        res = '0;
        bar = px / 4;
        case (c.mode)
            PAT_SOLID: res = c.bg;
            PAT_BARS: begin
                res.r = bar[2] ? 8'hff : 8'h00;
                res.g = bar[1] ? 8'hff : 8'h00;
                res.b = bar[0] ? 8'hff : 8'h00;
            end
            PAT_GRID: begin
                if ((px % 8 == 0) || (py % 8 == 0)) begin
                    res = 24'hffffff;
                end else begin
                    res = c.bg;
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    always @(posedge clk50) begin
        if (cfg_seq != seen_seq) begin
            seen_seq     <= cfg_seq;
            frames_since <= 0;
        end else if (rst_n && vga_ce && prev_vs && !vga_vs) begin
            frames_since <= frames_since + 1;
        end
    end

    // One sample per pixel, taken while the outputs are stable
    always @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            x        <= 0;
            y        <= 0;
            hs_gap   <= 0;
            vs_gap   <= 0;
            prev_de  <= 1'b0;
            prev_hs  <= 1'b1;
            prev_vs  <= 1'b1;
            seen_hs  <= 1'b0;
            seen_vs  <= 1'b0;
            vs_falls <= '0;
        end else if (vga_ce) begin
            if (armed) begin
                exp_pix = '0;
                if (vga_de) begin
                    exp_pix     = expected_rgb(x, y, exp_cfg);
                    pix_checked = pix_checked + 1;
                end
                pix_bad = value_differs("vga_r", 32'(exp_pix.r), 32'(vga_r)) |
                          value_differs("vga_g", 32'(exp_pix.g), 32'(vga_g)) |
                          value_differs("vga_b", 32'(exp_pix.b), 32'(vga_b));
                if (pix_bad) begin
                    $display("       pixel position x=%0d y=%0d", x, y);
                    pix_errors = pix_errors + 1;
                end
            end
            hs_gap <= hs_gap + 1;
            vs_gap <= vs_gap + 1;
            if (!vga_vs) begin
                x <= 0;
                y <= 0;
            end else if (vga_de) begin
                x <= x + 1;
            end else if (prev_de) begin
                if (x != `H_ACTIVE) begin
                    $display("Active line had %0d pixels instead of %0d", x, `H_ACTIVE);
                    timing_errors = timing_errors + 1;
                end
                x <= 0;
                y <= y + 1;
            end
            if (prev_hs && !vga_hs) begin
                if (seen_hs && hs_gap != `H_TOTAL) begin
                    $display("Line period was %0d pixels instead of %0d", hs_gap, `H_TOTAL);
                    timing_errors = timing_errors + 1;
                end
                seen_hs <= 1'b1;
                hs_gap  <= 1;
            end
            if (prev_vs && !vga_vs) begin
                if (seen_vs && vs_gap != `H_TOTAL * `V_TOTAL) begin
                    $display("Frame period was %0d pixels, not one full frame", vs_gap);
                    timing_errors = timing_errors + 1;
                end
                if (y != `V_ACTIVE) begin
                    $display("Frame had %0d active lines instead of %0d", y, `V_ACTIVE);
                    timing_errors = timing_errors + 1;
                end
                // Frames completed so far, one per vs falling edge
                if (value_differs("frame_cnt", vs_falls, frame_cnt)) begin
                    frame_errors = frame_errors + 1;
                end
                vs_falls <= vs_falls + `FRAME_CNT_W'(1);
                seen_vs  <= 1'b1;
                vs_gap   <= 1;
            end
            prev_de <= vga_de;
            prev_hs <= vga_hs;
            prev_vs <= vga_vs;
        end
    end

    // LED follows the frame counter one clock late
    always @(posedge clk50 or negedge rst_n) begin
        if (!rst_n) begin
            prev_fc <= '0;
        end else begin
            if (armed && value_differs("led_user", 32'(prev_fc[exp_cfg.blink_sel]),
                                       32'(led_user))) begin
                led_errors = led_errors + 1;
            end
            prev_fc <= frame_cnt;
        end
    end

endmodule

`default_nettype wire

/* verif/emu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defines.svh"

module emu_tb
    import video_pkg::*;
    import core_pkg::*;
();

    localparam int NUM_ENTRIES  = 7;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL * 2;
    localparam int WATCHDOG_NS  = (NUM_ENTRIES * 3 * FRAME_CYCLES + 2000) * 20;

    typedef struct packed {
        logic      addr_ok;
        logic      rand_bg;
        core_cfg_t cfg;
    } stim_t;

    logic                    clk50 = 1'b0;
    logic                    rst_n;
    logic                    cfg_wr;
    reg_addr_e               cfg_addr;
    logic [7:0]              cfg_data;
    logic                    vga_ce;
    logic [`COLOR_W-1:0]     vga_r;
    logic [`COLOR_W-1:0]     vga_g;
    logic [`COLOR_W-1:0]     vga_b;
    logic                    vga_hs;
    logic                    vga_vs;
    logic                    vga_de;
    logic [`FRAME_CNT_W-1:0] frame_cnt;
    logic                    led_user;
    integer                  seed;
    stim_t                   stim_tab [NUM_ENTRIES];

    always #10 clk50 = ~clk50;

    emu_core UUT (
        .clk50     ( clk50     ),
        .rst_n     ( rst_n     ),
        .cfg_wr    ( cfg_wr    ),
        .cfg_addr  ( cfg_addr  ),
        .cfg_data  ( cfg_data  ),
        .vga_ce    ( vga_ce    ),
        .vga_r     ( vga_r     ),
        .vga_g     ( vga_g     ),
        .vga_b     ( vga_b     ),
        .vga_hs    ( vga_hs    ),
        .vga_vs    ( vga_vs    ),
        .vga_de    ( vga_de    ),
        .frame_cnt ( frame_cnt ),
        .led_user  ( led_user  )
    );

    emu_checker u_checker (
        .clk50     ( clk50     ),
        .rst_n     ( rst_n     ),
        .vga_ce    ( vga_ce    ),
        .vga_r     ( vga_r     ),
        .vga_g     ( vga_g     ),
        .vga_b     ( vga_b     ),
        .vga_hs    ( vga_hs    ),
        .vga_vs    ( vga_vs    ),
        .vga_de    ( vga_de    ),
        .frame_cnt ( frame_cnt ),
        .led_user  ( led_user  )
    );

    function automatic stim_t make_entry(input pattern_e mode, input logic [23:0] bg,
                                         input logic [2:0] blink, input logic ok,
                                         input logic rnd);
        stim_t e;
        e.addr_ok       = ok;
        e.rand_bg       = rnd;
        e.cfg.mode      = mode;
        e.cfg.bg        = bg;
        e.cfg.blink_sel = blink;
        return e;
    endfunction

    // Undefined addresses 5..7 stand in for the real ones when ok is low
    function automatic reg_addr_e target_addr(input reg_addr_e good, input int k,
                                              input logic ok);
        if (ok) begin
            return good;
        end
        return reg_addr_e'(3'(5 + k % 3));
    endfunction

    task automatic load_table();
        stim_tab[0] = make_entry(PAT_SOLID, 24'h1080f0, 3'd0, 1'b1, 1'b0);
        stim_tab[1] = make_entry(PAT_SOLID, 24'h000000, 3'd1, 1'b1, 1'b1);
        stim_tab[2] = make_entry(PAT_BARS,  24'h55aa33, 3'd0, 1'b1, 1'b0);
        stim_tab[3] = make_entry(PAT_GRID,  24'h204060, 3'd1, 1'b1, 1'b0);
        stim_tab[4] = make_entry(PAT_GRID,  24'h000000, 3'd0, 1'b1, 1'b1);
        // Grid of the entry before keeps running
        stim_tab[5] = make_entry(PAT_BARS,  24'h0000ff, 3'd1, 1'b0, 1'b0);
        stim_tab[6] = make_entry(PAT_OFF,   24'h123456, 3'd0, 1'b1, 1'b0);
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [7:0] data);
        @(negedge clk50);
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        core_cfg_t   cur;
        core_cfg_t   next;
        logic [31:0] rnd;
        logic        ok;
        int          total;
        seed     = 79;
        rst_n    = 1'b0;
        cfg_wr   = 1'b0;
        cfg_addr = REG_MODE;
        cfg_data = '0;
        cur      = '{mode: PAT_OFF, bg: '0, blink_sel: '0};
        load_table();
        repeat (16) @(posedge clk50);
        @(negedge clk50);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(negedge vga_vs);
            next = stim_tab[i].cfg;
            ok   = stim_tab[i].addr_ok;
            if (stim_tab[i].rand_bg) begin
                rnd     = $random(seed);
                next.bg = rnd[23:0];
            end
            write_reg(target_addr(REG_MODE, 0, ok), {6'b0, next.mode});
            write_reg(target_addr(REG_BG_R, 1, ok), next.bg.r);
            write_reg(target_addr(REG_BG_G, 2, ok), next.bg.g);
            write_reg(target_addr(REG_BG_B, 3, ok), next.bg.b);
            write_reg(target_addr(REG_BLINK, 4, ok), {5'b0, next.blink_sel});
            @(negedge clk50);
            cfg_wr = 1'b0;
            if (ok) begin
                cur = next;
            end
            u_checker.exp_cfg = cur;
            u_checker.cfg_seq = u_checker.cfg_seq + 1;
            repeat (2) @(negedge vga_vs);
        end
        total = u_checker.pix_errors + u_checker.led_errors + u_checker.frame_errors +
                u_checker.timing_errors + UUT.u_timing.u_asserts.assert_errors;
        $display("Errors: pixel %0d, led %0d, frame %0d, timing %0d, assert %0d (%0d compared)",
                 u_checker.pix_errors, u_checker.led_errors, u_checker.frame_errors,
                 u_checker.timing_errors, UUT.u_timing.u_asserts.assert_errors,
                 u_checker.pix_checked);
        if (u_checker.pix_checked == 0) begin
            $display("No active pixels were compared during the run");
        end
        if (total == 0 && u_checker.pix_checked > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+rtl
rtl/video_pkg.sv
rtl/core_pkg.sv
rtl/video_timing.sv
rtl/core_regs.sv
rtl/pattern_gen.sv
rtl/emu_core.sv
verif/emu_asserts.sv
verif/emu_checker.sv
verif/emu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the simulation output
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module emu_tb -f build.f -o emu_sim &&
    ./obj_dir/emu_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
    echo "Result: pass" ||
    { echo "Result: fail"; exit 1; }
